/* source/soc_pkg.sv */
// Peripheral subsystem shared definitions
// Bus widths, address map regions, register offsets and the address word layout

package soc_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int OFFSET_WIDTH = 12;

	// AHB transfer types that start a real access
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ = 2'b11;

	// Address bits 15:12 pick the slave
	typedef enum logic [3:0] {
		REGION_GPIO = 4'h0,
		REGION_TIMER = 4'h1,
		REGION_KPLIC = 4'h2
	} region_e;

	typedef logic [OFFSET_WIDTH-1:0] reg_offset_t;

	typedef struct packed {
		logic [15:0] upper;
		region_e region;
		reg_offset_t offset;
	} bus_addr_fields_t;

	// Same bus word seen as raw address or as region and offset
	typedef union packed {
		logic [ADDR_WIDTH-1:0] raw;
		bus_addr_fields_t fields;
	} bus_addr_u;

	// GPIO registers
	localparam reg_offset_t GPIO_OUT_OFS = 12'h000;
	localparam reg_offset_t GPIO_IN_OFS = 12'h004;

	// Machine timer registers
	localparam reg_offset_t MTIME_LO_OFS = 12'h000;
	localparam reg_offset_t MTIME_HI_OFS = 12'h004;
	localparam reg_offset_t MTIMECMP_LO_OFS = 12'h008;
	localparam reg_offset_t MTIMECMP_HI_OFS = 12'h00C;

	// Interrupt controller registers
	localparam reg_offset_t KPLIC_PENDING_OFS = 12'h000;
	localparam reg_offset_t KPLIC_ENABLE_OFS = 12'h004;
	localparam reg_offset_t KPLIC_CLAIM_OFS = 12'h008;

endpackage

/* source/reg_bus_if.sv */
// Register bus for one slave during the AHB data phase
// Decoder side strobes sel, slave side returns read data in the same cycle

`timescale 1ns/10ps

interface reg_bus_if import soc_pkg::*; ();

	// One-cycle access strobe
	logic sel;
	logic write;
	reg_offset_t offset;
	logic [DATA_WIDTH-1:0] wdata;
	// Driven from offset without a clock
	logic [DATA_WIDTH-1:0] rdata;

	modport decoder (
		output sel,
		output write,
		output offset,
		output wdata,
		input rdata
	);

	modport slave (
		input sel,
		input write,
		input offset,
		input wdata,
		output rdata
	);

endinterface

/* source/ahb_decoder.sv */
// AHB-lite slave port and address decoder
// Captures the address phase, strobes one slave in the data phase, muxes its read data

`timescale 1ns/10ps

module ahb_decoder import soc_pkg::*; (
	input logic HCLK,
	input logic reset,
	input logic [ADDR_WIDTH-1:0] haddr,
	input logic [1:0] htrans,
	input logic hwrite,
	input logic [DATA_WIDTH-1:0] hwdata,
	output logic [DATA_WIDTH-1:0] hrdata,
	reg_bus_if.decoder gpio_bus,
	reg_bus_if.decoder timer_bus,
	reg_bus_if.decoder kplic_bus
);

	bus_addr_u addr_word;
	logic addr_valid;

	// Data phase state
	logic data_valid;
	region_e region_q;
	reg_offset_t offset_q;
	logic write_q;

	assign addr_word.raw = haddr;
	assign addr_valid = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);

	always_ff @(posedge HCLK) begin
		if (reset) begin
			data_valid <= 1'b0;
		end else begin
			data_valid <= addr_valid;
		end
	end

	// Address phase fields, held for the data phase
	always_ff @(posedge HCLK) begin
		if (addr_valid) begin
			region_q <= addr_word.fields.region;
			offset_q <= addr_word.fields.offset;
			write_q <= hwrite;
		end
	end

	// Only the captured region sees a strobe
	assign gpio_bus.sel = data_valid && (region_q == REGION_GPIO);
	assign timer_bus.sel = data_valid && (region_q == REGION_TIMER);
	assign kplic_bus.sel = data_valid && (region_q == REGION_KPLIC);

	assign gpio_bus.write = write_q;
	assign timer_bus.write = write_q;
	assign kplic_bus.write = write_q;

	assign gpio_bus.offset = offset_q;
	assign timer_bus.offset = offset_q;
	assign kplic_bus.offset = offset_q;

	// Write data arrives during the data phase itself
	assign gpio_bus.wdata = hwdata;
	assign timer_bus.wdata = hwdata;
	assign kplic_bus.wdata = hwdata;

	always_comb begin
		hrdata = '0;
		if (data_valid) begin
			case (region_q)
				REGION_GPIO: hrdata = gpio_bus.rdata;
				REGION_TIMER: hrdata = timer_bus.rdata;
				REGION_KPLIC: hrdata = kplic_bus.rdata;
				// Unmapped space reads zero
				default: hrdata = '0;
			endcase
		end
	end

endmodule

/* source/gpio.sv */
// GPIO block
// Output register plus a two-stage synchronizer on the inputs

`timescale 1ns/10ps

module gpio import soc_pkg::*; #(
	parameter int GPIO_WIDTH = 8
) (
	input logic HCLK,
	input logic reset,
	reg_bus_if.slave bus,
	input logic [GPIO_WIDTH-1:0] gpio_in,
	output logic [GPIO_WIDTH-1:0] gpio_out,
	output logic [GPIO_WIDTH-1:0] gpio_sync
);

	logic [GPIO_WIDTH-1:0] gpio_meta;

	always_ff @(posedge HCLK) begin
		if (reset) begin
			gpio_out <= '0;
		end else if (bus.sel && bus.write && (bus.offset == GPIO_OUT_OFS)) begin
			gpio_out <= bus.wdata[GPIO_WIDTH-1:0];
		end
	end

	// Pins are asynchronous to HCLK
	always_ff @(posedge HCLK) begin
		if (reset) begin
			gpio_meta <= '0;
			gpio_sync <= '0;
		end else begin
			gpio_meta <= gpio_in;
			gpio_sync <= gpio_meta;
		end
	end

	always_comb begin
		case (bus.offset)
			GPIO_OUT_OFS: bus.rdata = DATA_WIDTH'(gpio_out);
			GPIO_IN_OFS: bus.rdata = DATA_WIDTH'(gpio_sync);
			default: bus.rdata = '0;
		endcase
	end

endmodule

/* source/core_timer.sv */
// Machine timer
// Free-running 64-bit mtime against mtimecmp, raises the timer interrupt

`timescale 1ns/10ps

module core_timer import soc_pkg::*; (
	input logic HCLK,
	input logic reset,
	reg_bus_if.slave bus,
	output logic core_timer_int
);

	logic [2*DATA_WIDTH-1:0] mtime;
	logic [2*DATA_WIDTH-1:0] mtimecmp;
	logic wr_en;

	assign wr_en = bus.sel && bus.write;

	always_ff @(posedge HCLK) begin
		if (reset) begin
			mtime <= '0;
			mtimecmp <= '1;
		end else begin
			mtime <= mtime + 1'b1;
			// A word write replaces that half of the counter
			if (wr_en) begin
				case (bus.offset)
					MTIME_LO_OFS: begin
						mtime[DATA_WIDTH-1:0] <= bus.wdata;
					end
					MTIME_HI_OFS: begin
						mtime[2*DATA_WIDTH-1:DATA_WIDTH] <= bus.wdata;
					end
					MTIMECMP_LO_OFS: begin
						mtimecmp[DATA_WIDTH-1:0] <= bus.wdata;
					end
					MTIMECMP_HI_OFS: begin
						mtimecmp[2*DATA_WIDTH-1:DATA_WIDTH] <= bus.wdata;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Compare result, one cycle behind the counter
	always_ff @(posedge HCLK) begin
		if (reset) begin
			core_timer_int <= 1'b0;
		end else begin
			core_timer_int <= (mtime >= mtimecmp);
		end
	end

	always_comb begin
		case (bus.offset)
			MTIME_LO_OFS: bus.rdata = mtime[DATA_WIDTH-1:0];
			MTIME_HI_OFS: bus.rdata = mtime[2*DATA_WIDTH-1:DATA_WIDTH];
			MTIMECMP_LO_OFS: bus.rdata = mtimecmp[DATA_WIDTH-1:0];
			MTIMECMP_HI_OFS: bus.rdata = mtimecmp[2*DATA_WIDTH-1:DATA_WIDTH];
			default: bus.rdata = '0;
		endcase
	end

endmodule

/* source/kplic.sv */
// Interrupt controller
// Edge-triggered pending bits, enable mask, claim/complete and one interrupt line

`timescale 1ns/10ps

module kplic import soc_pkg::*; #(
	parameter int NUM_SOURCES = 8
) (
	input logic HCLK,
	input logic reset,
	reg_bus_if.slave bus,
	input logic [NUM_SOURCES-1:0] sources,
	output logic irq
);

	// Claim IDs run from 1 to NUM_SOURCES, zero means none
	localparam int ID_WIDTH = $clog2(NUM_SOURCES + 1);

	logic [NUM_SOURCES-1:0] sources_q;
	logic [NUM_SOURCES-1:0] rise;
	logic [NUM_SOURCES-1:0] pending;
	logic [NUM_SOURCES-1:0] enable;
	logic [NUM_SOURCES-1:0] active;
	logic [NUM_SOURCES-1:0] complete_mask;
	logic [ID_WIDTH-1:0] claim_id;
	logic complete_wr;

	assign rise = sources & ~sources_q;
	assign active = pending & enable;
	assign complete_wr = bus.sel && bus.write && (bus.offset == KPLIC_CLAIM_OFS);

	// Completion names the source by its ID
	always_comb begin
		for (int i = 0; i < NUM_SOURCES; i++) begin
			complete_mask[i] = complete_wr && (bus.wdata == DATA_WIDTH'(i + 1));
		end
	end

	// Lowest-numbered active source wins
	always_comb begin
		claim_id = '0;
		for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
			if (active[i]) begin
				claim_id = ID_WIDTH'(i + 1);
			end
		end
	end

	always_ff @(posedge HCLK) begin
		if (reset) begin
			sources_q <= '0;
			pending <= '0;
		end else begin
			sources_q <= sources;
			// New edge beats a completion of the same source
			pending <= (pending & ~complete_mask) | rise;
		end
	end

	always_ff @(posedge HCLK) begin
		if (reset) begin
			enable <= '0;
		end else if (bus.sel && bus.write && (bus.offset == KPLIC_ENABLE_OFS)) begin
			enable <= bus.wdata[NUM_SOURCES-1:0];
		end
	end

	always_ff @(posedge HCLK) begin
		if (reset) begin
			irq <= 1'b0;
		end else begin
			irq <= |active;
		end
	end

	// Claim read leaves pending alone
	always_comb begin
		case (bus.offset)
			KPLIC_PENDING_OFS: bus.rdata = DATA_WIDTH'(pending);
			KPLIC_ENABLE_OFS: bus.rdata = DATA_WIDTH'(enable);
			KPLIC_CLAIM_OFS: bus.rdata = DATA_WIDTH'(claim_id);
			default: bus.rdata = '0;
		endcase
	end

endmodule

/* source/periph_ss.sv */
// Peripheral subsystem top
// AHB-lite port, decoder, GPIO, machine timer and interrupt controller

`timescale 1ns/10ps

module periph_ss import soc_pkg::*; #(
	parameter int GPIO_WIDTH = 8
) (
	input logic HCLK,
	input logic reset,
	input logic [ADDR_WIDTH-1:0] haddr,
	input logic [1:0] htrans,
	input logic hwrite,
	input logic [DATA_WIDTH-1:0] hwdata,
	output logic [DATA_WIDTH-1:0] hrdata,
	input logic [GPIO_WIDTH-1:0] gpio_in,
	output logic [GPIO_WIDTH-1:0] gpio_out,
	output logic irq
);

	logic [GPIO_WIDTH-1:0] gpio_sync;
	logic core_timer_int;
	logic [GPIO_WIDTH-1:0] kplic_sources;

	reg_bus_if gpio_bus ();
	reg_bus_if timer_bus ();
	reg_bus_if kplic_bus ();

	// Source 0 is the timer, the rest are GPIO inputs
	assign kplic_sources = {gpio_sync[GPIO_WIDTH-1:1], core_timer_int};

	ahb_decoder u_ahb_decoder (
		.HCLK		(HCLK),
		.reset		(reset),
		.haddr		(haddr),
		.htrans		(htrans),
		.hwrite		(hwrite),
		.hwdata		(hwdata),
		.hrdata		(hrdata),
		.gpio_bus	(gpio_bus),
		.timer_bus	(timer_bus),
		.kplic_bus	(kplic_bus)
	);

	gpio #(
		.GPIO_WIDTH	(GPIO_WIDTH)
	) u_gpio (
		.HCLK		(HCLK),
		.reset		(reset),
		.bus		(gpio_bus),
		.gpio_in	(gpio_in),
		.gpio_out	(gpio_out),
		.gpio_sync	(gpio_sync)
	);

	core_timer u_core_timer (
		.HCLK		(HCLK),
		.reset		(reset),
		.bus		(timer_bus),
		.core_timer_int	(core_timer_int)
	);

	kplic #(
		.NUM_SOURCES	(GPIO_WIDTH)
	) u_kplic (
		.HCLK		(HCLK),
		.reset		(reset),
		.bus		(kplic_bus),
		.sources	(kplic_sources),
		.irq		(irq)
	);

endmodule

/* verif/tb_tasks.svh */
// Testbench helpers for the peripheral subsystem
// AHB-lite transfers, result checks and bounded polling
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Drive point sits just after the rising edge
task automatic next_cycle();
	@(posedge HCLK);
	#(DRIVE_DELAY);
endtask

task automatic start_transfer(input logic [ADDR_WIDTH-1:0] addr, input logic write);
	haddr = addr;
	htrans = HTRANS_NONSEQ;
	hwrite = write;
endtask

task automatic bus_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
	next_cycle();
	start_transfer(addr, 1'b1);
	next_cycle();
	htrans = HTRANS_IDLE;
	hwdata = data;
	next_cycle();
endtask

// Read data is taken just before the edge that closes the data phase
task automatic bus_read(input logic [ADDR_WIDTH-1:0] addr, output logic [DATA_WIDTH-1:0] data);
	next_cycle();
	start_transfer(addr, 1'b0);
	next_cycle();
	htrans = HTRANS_IDLE;
	#(SAMPLE_DELAY);
	data = hrdata;
	next_cycle();
endtask

// Read address phase overlaps the write data phase
task automatic write_then_read(input logic [ADDR_WIDTH-1:0] addr,
		input logic [DATA_WIDTH-1:0] wdata, output logic [DATA_WIDTH-1:0] rdata);
	next_cycle();
	start_transfer(addr, 1'b1);
	next_cycle();
	start_transfer(addr, 1'b0);
	hwdata = wdata;
	next_cycle();
	htrans = HTRANS_IDLE;
	#(SAMPLE_DELAY);
	rdata = hrdata;
	next_cycle();
endtask

task automatic read_pair(input logic [ADDR_WIDTH-1:0] addr_a, input logic [ADDR_WIDTH-1:0] addr_b,
		output logic [DATA_WIDTH-1:0] data_a, output logic [DATA_WIDTH-1:0] data_b);
	next_cycle();
	start_transfer(addr_a, 1'b0);
	next_cycle();
	start_transfer(addr_b, 1'b0);
	#(SAMPLE_DELAY);
	data_a = hrdata;
	next_cycle();
	htrans = HTRANS_IDLE;
	#(SAMPLE_DELAY);
	data_b = hrdata;
	next_cycle();
endtask

task automatic report_error(input string msg);
	$display("%s", msg);
	error_count++;
endtask

task automatic check_equal(input string name, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
	assert (actual === expected) else begin
		$display("[FAIL] %s: expected 0x%h, got 0x%h", name, expected, actual);
		error_count++;
	end
endtask

// Reread a register until its masked value matches
task automatic poll_register(input string name, input logic [ADDR_WIDTH-1:0] addr,
		input logic [DATA_WIDTH-1:0] mask, input logic [DATA_WIDTH-1:0] expected);
	logic [DATA_WIDTH-1:0] value;
	logic matched;
	int reads;
	matched = 1'b0;
	reads = 0;
	while (!matched && reads < POLL_READS) begin
		bus_read(addr, value);
		matched = ((value & mask) === expected);
		reads++;
	end
	if (!matched) begin
		report_error($sformatf("Timeout: %s never settled in %0d reads", name, POLL_READS));
	end
endtask

task automatic wait_for_irq(input int max_cycles);
	int cycles;
	cycles = 0;
	while (irq !== 1'b1 && cycles < max_cycles) begin
		next_cycle();
		cycles++;
	end
	if (irq !== 1'b1) begin
		report_error($sformatf("Timeout: irq did not rise within %0d cycles", max_cycles));
	end
endtask

// Complete every ID so that no stale pending bit is left
task automatic clear_all_pending();
	for (int id = 1; id <= GPIO_WIDTH; id++) begin
		bus_write(CLAIM_ADDR, DATA_WIDTH'(id));
	end
endtask

`endif

/* verif/tb_periph_ss.sv */
// Testbench for the peripheral subsystem
// Directed tests over the AHB-lite port, the GPIO pins and the interrupt line

`timescale 1ns/10ps

module tb_periph_ss import soc_pkg::*; ();

	localparam int GPIO_WIDTH = 8;
	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 1;
	localparam int SAMPLE_DELAY = CLK_PERIOD - 2 * DRIVE_DELAY;
	localparam int POLL_READS = 8;
	localparam int WATCHDOG_CYCLES = 5000;
	localparam logic [1:0] HTRANS_IDLE = 2'b00;

	// Register addresses from the address map
	localparam logic [ADDR_WIDTH-1:0] GPIO_OUT_ADDR = {16'h0, REGION_GPIO, GPIO_OUT_OFS};
	localparam logic [ADDR_WIDTH-1:0] GPIO_IN_ADDR = {16'h0, REGION_GPIO, GPIO_IN_OFS};
	localparam logic [ADDR_WIDTH-1:0] MTIME_LO_ADDR = {16'h0, REGION_TIMER, MTIME_LO_OFS};
	localparam logic [ADDR_WIDTH-1:0] MTIMECMP_LO_ADDR = {16'h0, REGION_TIMER, MTIMECMP_LO_OFS};
	localparam logic [ADDR_WIDTH-1:0] MTIMECMP_HI_ADDR = {16'h0, REGION_TIMER, MTIMECMP_HI_OFS};
	localparam logic [ADDR_WIDTH-1:0] PENDING_ADDR = {16'h0, REGION_KPLIC, KPLIC_PENDING_OFS};
	localparam logic [ADDR_WIDTH-1:0] ENABLE_ADDR = {16'h0, REGION_KPLIC, KPLIC_ENABLE_OFS};
	localparam logic [ADDR_WIDTH-1:0] CLAIM_ADDR = {16'h0, REGION_KPLIC, KPLIC_CLAIM_OFS};
	localparam logic [ADDR_WIDTH-1:0] UNMAPPED_ADDR = 32'h0000_5000;

	logic HCLK;
	logic reset;
	logic [ADDR_WIDTH-1:0] haddr;
	logic [1:0] htrans;
	logic hwrite;
	logic [DATA_WIDTH-1:0] hwdata;
	logic [DATA_WIDTH-1:0] hrdata;
	logic [GPIO_WIDTH-1:0] gpio_in;
	logic [GPIO_WIDTH-1:0] gpio_out;
	logic irq;
	integer seed;
	int error_count;
	int test_count;
	int failed_tests;

	periph_ss #(
		.GPIO_WIDTH	(GPIO_WIDTH)
	) UUT (
		.HCLK		(HCLK),
		.reset		(reset),
		.haddr		(haddr),
		.htrans		(htrans),
		.hwrite		(hwrite),
		.hwdata		(hwdata),
		.hrdata		(hrdata),
		.gpio_in	(gpio_in),
		.gpio_out	(gpio_out),
		.irq		(irq)
	);

	`include "tb_tasks.svh"

	initial begin
		HCLK = 1'b0;
		forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
	end

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("Test %s: ok", name);
		end else begin
			failed_tests++;
			$display("Test %s: %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic reset_and_unmapped();
		logic [DATA_WIDTH-1:0] data;
		int errors_before;
		errors_before = error_count;
		check_equal("gpio_out", '0, gpio_out);
		check_equal("irq", '0, irq);
		bus_read(ENABLE_ADDR, data);
		check_equal("kplic enable", '0, data);
		// Offsets 0 and 4 would reach gpio_out and the enable mask if region 5 leaked
		bus_write(UNMAPPED_ADDR, '1);
		bus_write(UNMAPPED_ADDR | 32'h4, '1);
		check_equal("gpio_out", '0, gpio_out);
		bus_read(UNMAPPED_ADDR, data);
		check_equal("hrdata region 5", '0, data);
		bus_read(ENABLE_ADDR, data);
		check_equal("kplic enable", '0, data);
		finish_test("reset values and unmapped space", errors_before);
	endtask

	task automatic gpio_loopback();
		logic [DATA_WIDTH-1:0] value;
		logic [DATA_WIDTH-1:0] data;
		logic [GPIO_WIDTH-1:0] pins;
		int errors_before;
		errors_before = error_count;
		value = $random(seed);
		bus_write(GPIO_OUT_ADDR, value);
		check_equal("gpio_out", DATA_WIDTH'(value[GPIO_WIDTH-1:0]), DATA_WIDTH'(gpio_out));
		bus_read(GPIO_OUT_ADDR, data);
		check_equal("gpio out register", DATA_WIDTH'(value[GPIO_WIDTH-1:0]), data);
		pins = $random(seed);
		gpio_in = pins;
		poll_register("gpio input register", GPIO_IN_ADDR, '1, DATA_WIDTH'(pins));
		bus_read(GPIO_IN_ADDR, data);
		check_equal("gpio input register", DATA_WIDTH'(pins), data);
		gpio_in = '0;
		poll_register("gpio input register", GPIO_IN_ADDR, '1, '0);
		finish_test("gpio loopback", errors_before);
	endtask

	task automatic timer_compare();
		logic [DATA_WIDTH-1:0] first;
		logic [DATA_WIDTH-1:0] second;
		int errors_before;
		errors_before = error_count;
		bus_read(MTIME_LO_ADDR, first);
		repeat (10) next_cycle();
		bus_read(MTIME_LO_ADDR, second);
		assert (second > first) else begin
			$display("[FAIL] mtime low word: 0x%h then 0x%h, no increase", first, second);
			error_count++;
		end
		bus_write(ENABLE_ADDR, 32'h1);
		bus_read(MTIME_LO_ADDR, first);
		// Low word first keeps the compare out of reach until the high word lands
		bus_write(MTIMECMP_LO_ADDR, first + 32'd40);
		bus_write(MTIMECMP_HI_ADDR, '0);
		check_equal("irq", '0, irq);
		wait_for_irq(100);
		bus_write(MTIMECMP_HI_ADDR, '1);
		bus_write(CLAIM_ADDR, 32'd1);
		bus_write(ENABLE_ADDR, '0);
		finish_test("timer counting and compare", errors_before);
	endtask

	task automatic claim_complete();
		logic [DATA_WIDTH-1:0] data;
		int errors_before;
		errors_before = error_count;
		clear_all_pending();
		bus_write(ENABLE_ADDR, 32'h24);
		gpio_in[5] = 1'b1;
		poll_register("pending bit 5", PENDING_ADDR, 32'h20, 32'h20);
		gpio_in[2] = 1'b1;
		poll_register("pending bits 2 and 5", PENDING_ADDR, 32'h24, 32'h24);
		bus_read(PENDING_ADDR, data);
		check_equal("kplic pending", 32'h24, data);
		// ID is the lowest enabled pending source plus one
		bus_read(CLAIM_ADDR, data);
		check_equal("kplic claim", 32'd3, data);
		check_equal("irq", 32'd1, irq);
		bus_write(CLAIM_ADDR, 32'd3);
		bus_read(CLAIM_ADDR, data);
		check_equal("kplic claim", 32'd6, data);
		bus_write(CLAIM_ADDR, 32'd6);
		bus_read(CLAIM_ADDR, data);
		check_equal("kplic claim", '0, data);
		check_equal("irq", '0, irq);
		gpio_in = '0;
		bus_write(ENABLE_ADDR, '0);
		poll_register("gpio input register", GPIO_IN_ADDR, '1, '0);
		finish_test("claim and complete", errors_before);
	endtask

	task automatic enable_masking();
		logic [DATA_WIDTH-1:0] data;
		int errors_before;
		errors_before = error_count;
		clear_all_pending();
		gpio_in[3] = 1'b1;
		poll_register("pending bit 3", PENDING_ADDR, 32'h08, 32'h08);
		bus_read(CLAIM_ADDR, data);
		check_equal("kplic claim", '0, data);
		check_equal("irq", '0, irq);
		bus_write(ENABLE_ADDR, 32'h08);
		wait_for_irq(10);
		bus_write(CLAIM_ADDR, 32'd4);
		bus_write(ENABLE_ADDR, '0);
		gpio_in = '0;
		finish_test("enable masking", errors_before);
	endtask

	task automatic back_to_back();
		logic [DATA_WIDTH-1:0] value;
		logic [DATA_WIDTH-1:0] first;
		logic [DATA_WIDTH-1:0] second;
		int errors_before;
		errors_before = error_count;
		value = $random(seed);
		write_then_read(GPIO_OUT_ADDR, value, first);
		check_equal("gpio out register", DATA_WIDTH'(value[GPIO_WIDTH-1:0]), first);
		bus_write(ENABLE_ADDR, 32'h5A);
		read_pair(GPIO_OUT_ADDR, ENABLE_ADDR, first, second);
		check_equal("gpio out register", DATA_WIDTH'(value[GPIO_WIDTH-1:0]), first);
		check_equal("kplic enable", 32'h5A, second);
		bus_write(ENABLE_ADDR, '0);
		finish_test("back-to-back transfers", errors_before);
	endtask

	initial begin
		error_count = 0;
		test_count = 0;
		failed_tests = 0;
		seed = 57;
		reset = 1'b1;
		haddr = '0;
		htrans = HTRANS_IDLE;
		hwrite = 1'b0;
		hwdata = '0;
		gpio_in = '0;
		repeat (5) @(posedge HCLK);
		#(DRIVE_DELAY);
		reset = 1'b0;
		reset_and_unmapped();
		gpio_loopback();
		timer_compare();
		claim_complete();
		enable_masking();
		back_to_back();
		$display("Summary: %0d tests run, %0d tests failed, %0d errors",
			test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Upper bound on the whole run
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge HCLK);
		$display("Simulation stopped: run exceeded %0d clock cycles", WATCHDOG_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+verif
source/soc_pkg.sv
source/reg_bus_if.sv
source/ahb_decoder.sv
source/gpio.sv
source/core_timer.sv
source/kplic.sv
source/periph_ss.sv
verif/tb_periph_ss.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module tb_periph_ss -f build.f -o tb_periph_ss \
	&& ./obj_dir/tb_periph_ss > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Verification passed" sim.log && echo "Simulation result: pass" \
	|| { echo "Simulation result: fail"; exit 1; }
